// ==== common/msp430Pkg.sv ====
package msp430Pkg;

   // Fetch starts here after reset
   localparam logic [15:0] resetAddr = 16'hF800;

   // Most extension words one instruction can carry
   localparam logic [1:0] maxExtWords = 2'd2;

   // Word class, from the top opcode bits
   typedef enum logic [1:0]
   {
      fmtIllegal = 2'd0,
      fmtOne     = 2'd1,
      fmtTwo     = 2'd2,
      fmtJump    = 2'd3
   } instrFormat_t;

   // Jump conditions in bits 12..10 of a jump word
   typedef enum logic [2:0]
   {
      jne = 3'd0,
      jeq = 3'd1,
      jnc = 3'd2,
      jc  = 3'd3,
      jn  = 3'd4,
      jge = 3'd5,
      jl  = 3'd6,
      jmp = 3'd7
   } jumpCond_t;

   // Function select
   // Jump codes keep the condition in the low three bits
   typedef enum logic [5:0]
   {
      fsJne  = 6'h00,
      fsJeq  = 6'h01,
      fsJnc  = 6'h02,
      fsJc   = 6'h03,
      fsJn   = 6'h04,
      fsJge  = 6'h05,
      fsJl   = 6'h06,
      fsJmp  = 6'h07,
      // Two-operand group
      fsMov  = 6'h10,
      fsAdd  = 6'h11,
      fsAddc = 6'h12,
      fsSubc = 6'h13,
      fsSub  = 6'h14,
      fsCmp  = 6'h15,
      fsDadd = 6'h16,
      fsBit  = 6'h17,
      fsBic  = 6'h18,
      fsBis  = 6'h19,
      fsXor  = 6'h1A,
      fsAnd  = 6'h1B,
      // Single-operand group
      fsRrc  = 6'h20,
      fsSwpb = 6'h21,
      fsRra  = 6'h22,
      fsSxt  = 6'h23,
      fsPush = 6'h24,
      fsCall = 6'h25,
      fsReti = 6'h26
   } aluFunc_t;

   // Format I opcodes, bits 15..12
   localparam logic [3:0] opFmtOne_MOV  = 4'h4;
   localparam logic [3:0] opFmtOne_ADD  = 4'h5;
   localparam logic [3:0] opFmtOne_ADDC = 4'h6;
   localparam logic [3:0] opFmtOne_SUBC = 4'h7;
   localparam logic [3:0] opFmtOne_SUB  = 4'h8;
   localparam logic [3:0] opFmtOne_CMP  = 4'h9;
   localparam logic [3:0] opFmtOne_DADD = 4'hA;
   localparam logic [3:0] opFmtOne_BIT  = 4'hB;
   localparam logic [3:0] opFmtOne_BIC  = 4'hC;
   localparam logic [3:0] opFmtOne_BIS  = 4'hD;
   localparam logic [3:0] opFmtOne_XOR  = 4'hE;
   localparam logic [3:0] opFmtOne_AND  = 4'hF;

   // Format II opcodes, bits 15..7
   localparam logic [8:0] opFmtTwo_RRC  = 9'h020;
   localparam logic [8:0] opFmtTwo_SWPB = 9'h021;
   localparam logic [8:0] opFmtTwo_RRA  = 9'h022;
   localparam logic [8:0] opFmtTwo_SXT  = 9'h023;
   localparam logic [8:0] opFmtTwo_PUSH = 9'h024;
   localparam logic [8:0] opFmtTwo_CALL = 9'h025;
   localparam logic [8:0] opFmtTwo_RETI = 9'h026;

   // Status bits seen by the jump test
   typedef struct packed
   {
      logic n;
      logic z;
      logic c;
      logic v;
   } statusFlags_t;

endpackage

// ==== common/decodeIf.sv ====
interface decodeIf;
   import msp430Pkg::*;

   // Opcode fields, latched with the opcode word
   instrFormat_t format;
   aluFunc_t     fs;
   logic         byteOp;
   logic         regWrite;
   logic         statusWrite;
   logic         illegal;
   logic [3:0]   srcReg;
   logic [3:0]   dstReg;
   logic [1:0]   srcMode;
   logic         dstMode;
   // Extension words still to come after the opcode
   logic [1:0]   extCount;

   // One-cycle strobes, one of them per sampled word
   logic         opStrobe;
   logic         extStrobe;
   logic [15:0]  extWord;

   modport decoder (
      output format, fs, byteOp, regWrite, statusWrite, illegal,
      output srcReg, dstReg, srcMode, dstMode, extCount,
      output opStrobe, extStrobe, extWord
   );

   modport collector (
      input format, fs, byteOp, regWrite, statusWrite, illegal,
      input srcReg, dstReg, srcMode, dstMode, extCount,
      input opStrobe, extStrobe, extWord
   );

endinterface

// ==== decode/opcodeTable.sv ====
module opcodeTable (
   input  logic [15:0]             word,
   output msp430Pkg::instrFormat_t format,
   output msp430Pkg::aluFunc_t     fs,
   output logic                    regWrite,
   output logic                    statusWrite,
   output logic                    illegal
);
   import msp430Pkg::*;

   // Classify the word and pick its function select
   always_comb
   begin
      format  = fmtIllegal;
      fs      = fsMov;
      illegal = 1'b1;
      if (word[15:13] == 3'b001)
      begin
         // Jump, condition goes straight into the select
         format  = fmtJump;
         fs      = aluFunc_t'({3'b000, word[12:10]});
         illegal = 1'b0;
      end
      else if (word[15:12] == 4'b0001)
      begin
         format  = fmtTwo;
         illegal = 1'b0;
         case (word[15:7])
            opFmtTwo_RRC:  fs = fsRrc;
            opFmtTwo_SWPB: fs = fsSwpb;
            opFmtTwo_RRA:  fs = fsRra;
            opFmtTwo_SXT:  fs = fsSxt;
            opFmtTwo_PUSH: fs = fsPush;
            opFmtTwo_CALL: fs = fsCall;
            opFmtTwo_RETI: fs = fsReti;
            default:
            begin
               // Unused single-operand slot
               format  = fmtIllegal;
               illegal = 1'b1;
            end
         endcase
      end
      else if (word[15:12] >= 4'b0100)
      begin
         format  = fmtOne;
         illegal = 1'b0;
         case (word[15:12])
            opFmtOne_MOV:  fs = fsMov;
            opFmtOne_ADD:  fs = fsAdd;
            opFmtOne_ADDC: fs = fsAddc;
            opFmtOne_SUBC: fs = fsSubc;
            opFmtOne_SUB:  fs = fsSub;
            opFmtOne_CMP:  fs = fsCmp;
            opFmtOne_DADD: fs = fsDadd;
            opFmtOne_BIT:  fs = fsBit;
            opFmtOne_BIC:  fs = fsBic;
            opFmtOne_BIS:  fs = fsBis;
            opFmtOne_XOR:  fs = fsXor;
            opFmtOne_AND:  fs = fsAnd;
            default:
            begin
               format  = fmtIllegal;
               illegal = 1'b1;
            end
         endcase
      end
   end

   // Write enables follow from the select
   // Jumps and illegal words write nothing
   always_comb
   begin
      regWrite    = 1'b0;
      statusWrite = 1'b0;
      if (format == fmtOne || format == fmtTwo)
      begin
         // Compare and test only set flags
         regWrite    = !(fs inside {fsCmp, fsBit});
         // Moves, bit set/clear, swap and stack ops leave flags alone
         statusWrite = !(fs inside {fsMov, fsBic, fsBis, fsSwpb, fsPush, fsCall});
      end
   end

endmodule

// ==== decode/instrDecoder.sv ====
module instrDecoder (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [15:0]             mdb,
   input  msp430Pkg::statusFlags_t statusFlags,
   output logic                    jumpTaken,
   output logic signed [9:0]       jumpOffset,
   decodeIf.decoder                dec
);
   import msp430Pkg::*;

   instrFormat_t wordFormat;
   aluFunc_t     wordFs;
   logic         wordRegWrite;
   logic         wordStatusWrite;
   logic         wordIllegal;

   // Outstanding extension words, zero means next word is an opcode
   logic [1:0]   extCnt;
   logic         isOpcode;
   logic         hasOperands;
   logic [3:0]   srcField;
   logic         srcNeedsExt;
   logic         dstNeedsExt;
   logic [1:0]   extNeeded;
   logic         condMet;

   opcodeTable table_i (
      .word        (mdb),
      .format      (wordFormat),
      .fs          (wordFs),
      .regWrite    (wordRegWrite),
      .statusWrite (wordStatusWrite),
      .illegal     (wordIllegal)
   );

   assign isOpcode    = (extCnt == 2'd0);
   assign hasOperands = (wordFormat == fmtOne) || (wordFormat == fmtTwo);
   // Format II has its only register in the low nibble
   assign srcField    = (wordFormat == fmtTwo) ? mdb[3:0] : mdb[11:8];

   // Indexed source (R3 excluded) or immediate through R0
   assign srcNeedsExt = hasOperands &&
                        ((mdb[5:4] == 2'b01 && srcField != 4'd3) ||
                         (mdb[5:4] == 2'b11 && srcField == 4'd0));
   // Indexed destination, two-operand only
   assign dstNeedsExt = (wordFormat == fmtOne) && mdb[7];
   assign extNeeded   = {1'b0, srcNeedsExt} + {1'b0, dstNeedsExt};

   // Jump condition against the live flags
   always_comb
   begin
      case (jumpCond_t'(mdb[12:10]))
         jne: condMet = !statusFlags.z;
         jeq: condMet = statusFlags.z;
         jnc: condMet = !statusFlags.c;
         jc:  condMet = statusFlags.c;
         jn:  condMet = statusFlags.n;
         jge: condMet = !(statusFlags.n ^ statusFlags.v);
         jl:  condMet = statusFlags.n ^ statusFlags.v;
         jmp: condMet = 1'b1;
      endcase
   end

   // Redirect only on an opcode word, never on an extension word
   assign jumpTaken  = isOpcode && (wordFormat == fmtJump) && condMet;
   assign jumpOffset = $signed(mdb[9:0]);

   // Word sequencing
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         extCnt        <= 2'd0;
         dec.opStrobe  <= 1'b0;
         dec.extStrobe <= 1'b0;
      end
      else
      begin
         dec.opStrobe  <= isOpcode;
         dec.extStrobe <= !isOpcode;
         if (isOpcode)
            extCnt <= extNeeded;
         else
            extCnt <= extCnt - 2'd1;
      end
   end

   // Field latches
   always_ff @(posedge clk)
   begin
      if (isOpcode)
      begin
         dec.format      <= wordFormat;
         dec.fs          <= wordFs;
         dec.regWrite    <= wordRegWrite;
         dec.statusWrite <= wordStatusWrite;
         dec.illegal     <= wordIllegal;
         dec.extCount    <= extNeeded;
         // Operand fields are zero for jumps and illegal words
         dec.byteOp      <= hasOperands && mdb[6];
         dec.srcReg      <= hasOperands ? srcField : 4'd0;
         dec.dstReg      <= hasOperands ? mdb[3:0] : 4'd0;
         dec.srcMode     <= hasOperands ? mdb[5:4] : 2'b00;
         dec.dstMode     <= dstNeedsExt;
      end
      else
      begin
         dec.extWord <= mdb;
      end
   end

   strobeExclusive: assert property (
      @(posedge clk) disable iff (reset) !(dec.opStrobe && dec.extStrobe))
      else $error("opcode and extension strobes together");

endmodule

// ==== rtl/programCounter.sv ====
module programCounter (
   input  logic              clk,
   input  logic              reset,
   input  logic              jumpTaken,
   input  logic signed [9:0] jumpOffset,
   output logic [15:0]       pcAddr
);
   import msp430Pkg::*;

   // Word offset scaled to bytes and sign extended
   logic [15:0] byteOffset;
   logic [15:0] nextSeq;

   assign byteOffset = {{5{jumpOffset[9]}}, jumpOffset, 1'b0};
   assign nextSeq    = pcAddr + 16'd2;

   // One word per cycle, target relative to the word after the jump
   always_ff @(posedge clk)
   begin
      if (reset)
         pcAddr <= resetAddr;
      else if (jumpTaken)
         pcAddr <= nextSeq + byteOffset;
      else
         pcAddr <= nextSeq;
   end

   // Fetch address stays word aligned, jumps included
   pcAligned: assert property (
      @(posedge clk) disable iff (reset) pcAddr[0] == 1'b0)
      else $error("odd fetch address");

endmodule

// ==== rtl/operandCollector.sv ====
module operandCollector (
   input  logic                    clk,
   input  logic                    reset,
   decodeIf.collector              dec,
   output logic                    instrValid,
   output logic [15:0]             srcExt,
   output logic [15:0]             dstExt,
   output msp430Pkg::instrFormat_t format,
   output msp430Pkg::aluFunc_t     fs,
   output logic                    illegal,
   output logic                    byteOp,
   output logic                    regWrite,
   output logic                    statusWrite,
   output logic [3:0]              srcReg,
   output logic [3:0]              dstReg,
   output logic [1:0]              srcMode,
   output logic                    dstMode
);
   import msp430Pkg::*;

   // Extension words still owed to the pending instruction
   logic [1:0]  pending;
   // Next extension word belongs to the source slot
   logic        toSrc;
   logic [15:0] srcHold;
   logic        srcHasExt;
   logic        lastExt;
   logic        issue;

   // With a single word, it is the destination's only if Ad is set
   assign srcHasExt = (dec.extCount == 2'd2) || !(dec.format == fmtOne && dec.dstMode);
   assign lastExt   = dec.extStrobe && (pending == 2'd1);
   assign issue     = (dec.opStrobe && dec.extCount == 2'd0) || lastExt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pending    <= 2'd0;
         toSrc      <= 1'b0;
         instrValid <= 1'b0;
      end
      else
      begin
         instrValid <= issue;
         if (dec.opStrobe)
         begin
            pending <= dec.extCount;
            toSrc   <= srcHasExt;
         end
         else if (dec.extStrobe)
         begin
            pending <= pending - 2'd1;
            // Second word is always the destination
            toSrc   <= 1'b0;
         end
      end
   end

   // Source word waits here until the instruction is complete
   always_ff @(posedge clk)
   begin
      if (dec.opStrobe)
         srcHold <= 16'h0000;
      else if (dec.extStrobe && toSrc)
         srcHold <= dec.extWord;
   end

   // Decoder fields still belong to this instruction at issue
   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         format      <= dec.format;
         fs          <= dec.fs;
         illegal     <= dec.illegal;
         byteOp      <= dec.byteOp;
         regWrite    <= dec.regWrite;
         statusWrite <= dec.statusWrite;
         srcReg      <= dec.srcReg;
         dstReg      <= dec.dstReg;
         srcMode     <= dec.srcMode;
         dstMode     <= dec.dstMode;
         if (lastExt)
         begin
            srcExt <= toSrc ? dec.extWord : srcHold;
            dstExt <= toSrc ? 16'h0000 : dec.extWord;
         end
         else
         begin
            // Single-word instruction, no operand words
            srcExt <= 16'h0000;
            dstExt <= 16'h0000;
         end
      end
   end

   // Decoder only sends extension words an opcode announced
   extExpected: assert property (
      @(posedge clk) disable iff (reset) dec.extStrobe |-> pending != 2'd0)
      else $error("extension word with no instruction pending");

endmodule

// ==== rtl/fetchDecodeTop.sv ====
module fetchDecodeTop (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [15:0]             mdb,
   input  msp430Pkg::statusFlags_t statusFlags,
   output logic [15:0]             pcAddr,
   output logic                    instrValid,
   output logic                    illegal,
   output msp430Pkg::instrFormat_t format,
   output msp430Pkg::aluFunc_t     fs,
   output logic                    byteOp,
   output logic                    regWrite,
   output logic                    statusWrite,
   output logic [3:0]              srcReg,
   output logic [3:0]              dstReg,
   output logic [1:0]              srcMode,
   output logic                    dstMode,
   output logic [15:0]             srcExt,
   output logic [15:0]             dstExt
);

   // Decoder to collector bundle
   decodeIf decBus ();

   // Jump redirect, combinational from the sampled word
   logic              jumpTaken;
   logic signed [9:0] jumpOffset;

   programCounter pc_i (
      .clk        (clk),
      .reset      (reset),
      .jumpTaken  (jumpTaken),
      .jumpOffset (jumpOffset),
      .pcAddr     (pcAddr)
   );

   instrDecoder decoder_i (
      .clk         (clk),
      .reset       (reset),
      .mdb         (mdb),
      .statusFlags (statusFlags),
      .jumpTaken   (jumpTaken),
      .jumpOffset  (jumpOffset),
      .dec         (decBus.decoder)
   );

   operandCollector collector_i (
      .clk         (clk),
      .reset       (reset),
      .dec         (decBus.collector),
      .instrValid  (instrValid),
      .srcExt      (srcExt),
      .dstExt      (dstExt),
      .format      (format),
      .fs          (fs),
      .illegal     (illegal),
      .byteOp      (byteOp),
      .regWrite    (regWrite),
      .statusWrite (statusWrite),
      .srcReg      (srcReg),
      .dstReg      (dstReg),
      .srcMode     (srcMode),
      .dstMode     (dstMode)
   );

endmodule

// ==== test/clockGen.sv ====
module clockGen #(
   parameter int resetCycles = 5
) (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   // Free-running 10 ns clock
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Held over the first rising edges, dropped on a falling edge
   initial
   begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// ==== test/fetchDecodeTb.sv ====
module fetchDecodeTb;
   timeunit 1ns;
   timeprecision 1ps;
   import msp430Pkg::*;

   localparam int resetCycles = 5;
   localparam int memWords    = 32768;
   localparam int numEntries  = 23;
   localparam logic [31:0] fillSeed = 32'hd8519b83;

   // One instruction in execution order
   typedef struct packed
   {
      logic [15:0]  addr;
      logic [1:0]   len;
      logic [15:0]  w0;
      logic [15:0]  w1;
      logic [15:0]  w2;
      statusFlags_t flags;
      instrFormat_t format;
      aluFunc_t     fs;
      logic         illegal;
      logic         byteOp;
      logic         regWrite;
      logic         statusWrite;
      logic [3:0]   srcReg;
      logic [3:0]   dstReg;
      logic [1:0]   srcMode;
      logic         dstMode;
      logic [15:0]  srcExt;
      logic [15:0]  dstExt;
      logic [15:0]  nextAddr;
   } entry_t;

   // addr, words, w0, w1, w2, flags {n,z,c,v}, format, fs
   // illegal, byte, regWrite, statusWrite, src, dst, As, Ad, srcExt, dstExt, next addr
   localparam entry_t instrTable [numEntries] = '{
      // Register-mode two-operand
      '{16'hF800, 2'd1, 16'h4A0B, 16'h0, 16'h0, 4'b0000, fmtOne, fsMov,
        1'b0, 1'b0, 1'b1, 1'b0, 4'hA, 4'hB, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF802},
      '{16'hF802, 2'd1, 16'h5546, 16'h0, 16'h0, 4'b0010, fmtOne, fsAdd,
        1'b0, 1'b1, 1'b1, 1'b1, 4'h5, 4'h6, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF804},
      '{16'hF804, 2'd1, 16'h9407, 16'h0, 16'h0, 4'b0000, fmtOne, fsCmp,
        1'b0, 1'b0, 1'b0, 1'b1, 4'h4, 4'h7, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF806},
      '{16'hF806, 2'd1, 16'hB849, 16'h0, 16'h0, 4'b0000, fmtOne, fsBit,
        1'b0, 1'b1, 1'b0, 1'b1, 4'h8, 4'h9, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF808},
      '{16'hF808, 2'd1, 16'hD102, 16'h0, 16'h0, 4'b0000, fmtOne, fsBis,
        1'b0, 1'b0, 1'b1, 1'b0, 4'h1, 4'h2, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF80A},
      // Indexed source, immediate source, indexed destination
      '{16'hF80A, 2'd2, 16'h8516, 16'h0004, 16'h0, 4'b0000, fmtOne, fsSub,
        1'b0, 1'b0, 1'b1, 1'b1, 4'h5, 4'h6, 2'd1, 1'b0, 16'h0004, 16'h0, 16'hF80E},
      '{16'hF80E, 2'd2, 16'h4037, 16'h1234, 16'h0, 4'b0000, fmtOne, fsMov,
        1'b0, 1'b0, 1'b1, 1'b0, 4'h0, 4'h7, 2'd3, 1'b0, 16'h1234, 16'h0, 16'hF812},
      '{16'hF812, 2'd2, 16'hE489, 16'h0006, 16'h0, 4'b0000, fmtOne, fsXor,
        1'b0, 1'b0, 1'b1, 1'b1, 4'h4, 4'h9, 2'd0, 1'b1, 16'h0, 16'h0006, 16'hF816},
      // Both operands indexed
      '{16'hF816, 2'd3, 16'hFADB, 16'h0002, 16'h0008, 4'b0000, fmtOne, fsAnd,
        1'b0, 1'b1, 1'b1, 1'b1, 4'hA, 4'hB, 2'd1, 1'b1, 16'h0002, 16'h0008, 16'hF81C},
      // R3 with As=01 needs no word
      '{16'hF81C, 2'd1, 16'h631C, 16'h0, 16'h0, 4'b0000, fmtOne, fsAddc,
        1'b0, 1'b0, 1'b1, 1'b1, 4'h3, 4'hC, 2'd1, 1'b0, 16'h0, 16'h0, 16'hF81E},
      // Single-operand group
      '{16'hF81E, 2'd1, 16'h1005, 16'h0, 16'h0, 4'b0000, fmtTwo, fsRrc,
        1'b0, 1'b0, 1'b1, 1'b1, 4'h5, 4'h5, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF820},
      '{16'hF820, 2'd2, 16'h1096, 16'h0004, 16'h0, 4'b0000, fmtTwo, fsSwpb,
        1'b0, 1'b0, 1'b1, 1'b0, 4'h6, 4'h6, 2'd1, 1'b0, 16'h0004, 16'h0, 16'hF824},
      '{16'hF824, 2'd1, 16'h1247, 16'h0, 16'h0, 4'b0000, fmtTwo, fsPush,
        1'b0, 1'b1, 1'b1, 1'b0, 4'h7, 4'h7, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF826},
      '{16'hF826, 2'd2, 16'h12B0, 16'hC000, 16'h0, 4'b0000, fmtTwo, fsCall,
        1'b0, 1'b0, 1'b1, 1'b0, 4'h0, 4'h0, 2'd3, 1'b0, 16'hC000, 16'h0, 16'hF82A},
      '{16'hF82A, 2'd1, 16'h1300, 16'h0, 16'h0, 4'b0000, fmtTwo, fsReti,
        1'b0, 1'b0, 1'b1, 1'b1, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF82C},
      // Zero word, then unused single-operand slot with As=01
      '{16'hF82C, 2'd1, 16'h0000, 16'h0, 16'h0, 4'b0000, fmtIllegal, fsMov,
        1'b1, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF82E},
      '{16'hF82E, 2'd1, 16'h1395, 16'h0, 16'h0, 4'b0000, fmtIllegal, fsMov,
        1'b1, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF830},
      // JEQ taken forward, JNE falls through
      '{16'hF830, 2'd1, 16'h2408, 16'h0, 16'h0, 4'b0100, fmtJump, fsJeq,
        1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF842},
      '{16'hF842, 2'd1, 16'h23F0, 16'h0, 16'h0, 4'b0100, fmtJump, fsJne,
        1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF844},
      // JL taken backward into the skipped gap
      '{16'hF844, 2'd1, 16'h3BF8, 16'h0, 16'h0, 4'b1000, fmtJump, fsJl,
        1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF836},
      '{16'hF836, 2'd1, 16'h3C0C, 16'h0, 16'h0, 4'b0000, fmtJump, fsJmp,
        1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF850},
      // Carry clear, so JC falls through
      '{16'hF850, 2'd1, 16'h2C05, 16'h0, 16'h0, 4'b0000, fmtJump, fsJc,
        1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF852},
      '{16'hF852, 2'd1, 16'h7D0E, 16'h0, 16'h0, 4'b0000, fmtOne, fsSubc,
        1'b0, 1'b0, 1'b1, 1'b1, 4'hD, 4'hE, 2'd0, 1'b0, 16'h0, 16'h0, 16'hF854}
   };

   logic         clk;
   logic         reset;
   logic [15:0]  mdb;
   statusFlags_t statusFlags;
   logic [15:0]  pcAddr;
   logic         instrValid;
   logic         illegal;
   instrFormat_t format;
   aluFunc_t     fs;
   logic         byteOp;
   logic         regWrite;
   logic         statusWrite;
   logic [3:0]   srcReg;
   logic [3:0]   dstReg;
   logic [1:0]   srcMode;
   logic         dstMode;
   logic [15:0]  srcExt;
   logic [15:0]  dstExt;

   // Instruction memory, word addressed
   logic [15:0]  mem [memWords];

   int           cycle;
   int           cycleLimit;
   int           totalWords;
   // Fetch side position and expected next address
   int           fIdx;
   int           fWord;
   logic [15:0]  expFetch;
   // Next table entry to be issued
   int           cIdx;

   clockGen #(.resetCycles(resetCycles)) clock_i (
      .clk   (clk),
      .reset (reset)
   );

   fetchDecodeTop dut_i (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic expectField(input int entry, input string what,
                              input logic [15:0] got, input logic [15:0] exp);
      assert (got == exp)
      else
      begin
         $display("** Error at %0t ns: entry %0d %s is %h, expected %h",
                  $time, entry, what, got, exp);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic loadMemory();
      logic [31:0] h;
      logic [14:0] a;
      int          i;
      for (i = 0; i < memWords; i++)
      begin
         h = xorshift(fillSeed ^ 32'(i));
         // Register-mode MOV, one word, registers from the hash
         mem[i] = {opFmtOne_MOV, h[11:8], 1'b0, h[6], 2'b00, h[3:0]};
      end
      for (i = 0; i < numEntries; i++)
      begin
         a = instrTable[i].addr[15:1];
         mem[a] = instrTable[i].w0;
         if (instrTable[i].len > 2'd1)
            mem[a + 15'd1] = instrTable[i].w1;
         if (instrTable[i].len > 2'd2)
            mem[a + 15'd2] = instrTable[i].w2;
      end
   endtask

   // One word per cycle, then on to the entry's successor
   task automatic checkFetch();
      expectField(fIdx, "pcAddr", pcAddr, expFetch);
      fWord = fWord + 1;
      if (fWord == int'(instrTable[fIdx].len))
      begin
         expFetch = instrTable[fIdx].nextAddr;
         fIdx     = fIdx + 1;
         fWord    = 0;
      end
      else
         expFetch = expFetch + 16'd2;
   endtask

   task automatic checkDecode(input entry_t e);
      expectField(cIdx, "format", 16'(format), 16'(e.format));
      expectField(cIdx, "fs", 16'(fs), 16'(e.fs));
      expectField(cIdx, "illegal", 16'(illegal), 16'(e.illegal));
      expectField(cIdx, "byteOp", 16'(byteOp), 16'(e.byteOp));
      expectField(cIdx, "regWrite", 16'(regWrite), 16'(e.regWrite));
      expectField(cIdx, "statusWrite", 16'(statusWrite), 16'(e.statusWrite));
      expectField(cIdx, "srcReg", 16'(srcReg), 16'(e.srcReg));
      expectField(cIdx, "dstReg", 16'(dstReg), 16'(e.dstReg));
      expectField(cIdx, "srcMode", 16'(srcMode), 16'(e.srcMode));
      expectField(cIdx, "dstMode", 16'(dstMode), 16'(e.dstMode));
      expectField(cIdx, "srcExt", srcExt, e.srcExt);
      expectField(cIdx, "dstExt", dstExt, e.dstExt);
   endtask

   initial
   begin
      mdb         = 16'h0000;
      statusFlags = '0;
      cycle       = 0;
      fIdx        = 0;
      fWord       = 0;
      cIdx        = 0;
      totalWords  = 0;
      loadMemory();
      expFetch = instrTable[0].addr;
      for (int i = 0; i < numEntries; i++)
         totalWords = totalWords + int'(instrTable[i].len);
      cycleLimit = 4 * totalWords + 50;

      while (cIdx < numEntries && cycle < cycleLimit)
      begin
         @(negedge clk);
         cycle = cycle + 1;
         mdb   = mem[pcAddr[15:1]];
         // Flags belong to the entry being fetched
         if (fIdx < numEntries)
            statusFlags = instrTable[fIdx].flags;
         else
            statusFlags = '0;
         if (cycle <= resetCycles)
         begin
            expectField(0, "pcAddr in reset", pcAddr, resetAddr);
            expectField(0, "instrValid in reset", 16'(instrValid), 16'h0000);
         end
         // Last reset edge done, this address is the first fetch
         if (cycle >= resetCycles && fIdx < numEntries)
            checkFetch();
         if (instrValid)
         begin
            checkDecode(instrTable[cIdx]);
            cIdx = cIdx + 1;
         end
      end

      if (cIdx == numEntries)
      begin
         $display("sim passed");
         $finish;
      end
      else
      begin
         $display("Timeout after %0d cycles, only %0d of %0d instructions were issued",
                  cycle, cIdx, numEntries);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

endmodule

// ==== fetchDecodeTop.f ====
common/msp430Pkg.sv
common/decodeIf.sv
decode/opcodeTable.sv
decode/instrDecoder.sv
rtl/programCounter.sv
rtl/operandCollector.sv
rtl/fetchDecodeTop.sv
test/clockGen.sv
test/fetchDecodeTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the fetch/decode testbench with Verilator and run it
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module fetchDecodeTb \
   -f fetchDecodeTop.f -Mdir obj_dir -o fetchDecodeSim > sim.log 2>&1 \
   && ./obj_dir/fetchDecodeSim >> sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
